// ==== rv_settings.svh ====
// rv32i pipeline core shared widths and data memory depth
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// data path and instruction word width
`define RV_XLEN 32

// byte address program counter, 256 bytes of program space
`define RV_PC_W 8

// register index, 32 architectural registers
`define RV_REG_W 5

// data ram depth in 32-bit words
`define RV_DMEM_WORDS 64

`endif

// ==== rv_pkg.sv ====
// rv32i pipeline core types, opcode encodings and stage register structs
`default_nettype none

`include "rv_settings.svh"

package rv_pkg;

    typedef logic [`RV_XLEN-1:0]  word_t;
    typedef logic [`RV_PC_W-1:0]  pc_t;
    typedef logic [`RV_REG_W-1:0] reg_idx_t;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        op_r      = 7'b0110011,
        op_imm    = 7'b0010011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_branch = 7'b1100011
    } opcode_e;

    typedef enum logic {
        alu_add = 1'b0,
        alu_sub = 1'b1
    } alu_op_e;

    // fetched word plus the sliced fields
    typedef struct packed {
        logic     valid;
        pc_t      pc;
        word_t    instr;
        opcode_e  opcode;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
    } if_id_t;

    // decoded operands and control
    typedef struct packed {
        logic     valid;
        pc_t      pc;
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        word_t    rs1_val;
        word_t    rs2_val;
        word_t    imm;
        alu_op_e  alu_op;
        logic     use_imm;
        logic     reg_write;
        logic     mem_read;
        logic     mem_write;
        logic     branch;
    } id_ex_t;

    // alu result doubles as the memory address
    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        word_t    alu_res;
        word_t    store_data;
        logic     reg_write;
        logic     mem_read;
        logic     mem_write;
    } ex_mem_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        word_t    data;
        logic     reg_write;
    } mem_wb_t;

endpackage

`default_nettype wire

// ==== fetch_stage.sv ====
// fetch stage with program counter and the IF/ID register
`default_nettype none
`timescale 1ns/1ns

module fetch_stage (
    input  logic           clk,
    input  logic           reset,
    input  rv_pkg::word_t  imem_data,
    input  logic           stall,
    input  logic           redirect,
    input  rv_pkg::pc_t    redirect_pc,
    output rv_pkg::pc_t    imem_addr,
    output rv_pkg::if_id_t if_id
);
    import rv_pkg::*;

    pc_t    pc;
    if_id_t fetched;

    // redirect beats stall, stall freezes the pc
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else if (redirect) begin
            pc <= redirect_pc;
        end else if (!stall) begin
            pc <= pc + pc_t'(4);
        end
    end

    // instruction memory answers in the same cycle
    assign imem_addr = pc;

    // field slicing of the fetched word
    always_comb begin
        fetched.valid  = 1'b1;
        fetched.pc     = pc;
        fetched.instr  = imem_data;
        fetched.opcode = opcode_e'(imem_data[6:0]);
        fetched.rd     = imem_data[11:7];
        fetched.rs1    = imem_data[19:15];
        fetched.rs2    = imem_data[24:20];
    end

    // hold on stall, flush to bubble on redirect
    always_ff @(posedge clk) begin
        if (redirect || !stall) begin
            if_id <= fetched;
        end
        // valid only, payload is don't care once cleared
        if (reset || redirect) begin
            if_id.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== decode_stage.sv ====
// decode stage with register file, load-use detection and the ID/EX register
`default_nettype none
`timescale 1ns/1ns

module decode_stage (
    input  logic            clk,
    input  logic            reset,
    input  rv_pkg::if_id_t  if_id,
    input  logic            flush,
    input  rv_pkg::mem_wb_t mem_wb,
    output rv_pkg::id_ex_t  id_ex,
    output logic            stall
);
    import rv_pkg::*;

    localparam int unsigned num_regs = 2 ** $bits(reg_idx_t);

    word_t      regs [num_regs];
    logic       wb_en;
    logic [2:0] funct3;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    id_ex_t     dec;

    // register read with same-cycle write bypass, x0 pinned to zero
    function automatic word_t rf_read(reg_idx_t idx);
        word_t val;
        if (idx == '0) begin
            val = '0;
        end else if (wb_en && (mem_wb.rd == idx)) begin
            val = mem_wb.data;
        end else begin
            val = regs[idx];
        end
        return val;
    endfunction

    assign wb_en = mem_wb.valid && mem_wb.reg_write && (mem_wb.rd != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en) begin
            regs[mem_wb.rd] <= mem_wb.data;
        end
    end

    // immediates, B form is already shifted by one
    assign funct3 = if_id.instr[14:12];
    assign imm_i  = {{20{if_id.instr[31]}}, if_id.instr[31:20]};
    assign imm_s  = {{20{if_id.instr[31]}}, if_id.instr[31:25], if_id.instr[11:7]};
    assign imm_b  = {{19{if_id.instr[31]}}, if_id.instr[31], if_id.instr[7],
                     if_id.instr[30:25], if_id.instr[11:8], 1'b0};

    always_comb begin
        dec.valid     = if_id.valid;
        dec.pc        = if_id.pc;
        dec.rs1       = if_id.rs1;
        dec.rs2       = if_id.rs2;
        dec.rd        = if_id.rd;
        dec.rs1_val   = rf_read(if_id.rs1);
        dec.rs2_val   = rf_read(if_id.rs2);
        dec.imm       = imm_i;
        dec.alu_op    = alu_add;
        dec.use_imm   = 1'b0;
        dec.reg_write = 1'b0;
        dec.mem_read  = 1'b0;
        dec.mem_write = 1'b0;
        dec.branch    = 1'b0;
        // anything unmatched stays valid with all writes off
        case (if_id.opcode)
            op_r: begin
                if (funct3 == 3'b000) begin
                    dec.reg_write = 1'b1;
                    // funct7 bit 30 picks sub
                    if (if_id.instr[30]) begin
                        dec.alu_op = alu_sub;
                    end
                end
            end
            op_imm: begin
                if (funct3 == 3'b000) begin
                    dec.use_imm   = 1'b1;
                    dec.reg_write = 1'b1;
                end
            end
            op_load: begin
                if (funct3 == 3'b010) begin
                    dec.use_imm   = 1'b1;
                    dec.reg_write = 1'b1;
                    dec.mem_read  = 1'b1;
                end
            end
            op_store: begin
                if (funct3 == 3'b010) begin
                    dec.imm       = imm_s;
                    dec.use_imm   = 1'b1;
                    dec.mem_write = 1'b1;
                end
            end
            op_branch: begin
                if (funct3 == 3'b000) begin
                    dec.imm    = imm_b;
                    dec.branch = 1'b1;
                end
            end
            default: begin
                dec.branch = 1'b0;
            end
        endcase
    end

    // load in EX whose rd feeds the instruction waiting in ID
    assign stall = id_ex.valid && id_ex.mem_read && (id_ex.rd != '0) && if_id.valid &&
                   ((id_ex.rd == if_id.rs1) || (id_ex.rd == if_id.rs2));

    // bubble on stall or flush
    always_ff @(posedge clk) begin
        id_ex <= dec;
        if (reset || stall || flush) begin
            id_ex.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== execute_stage.sv ====
// execute stage with forwarding, alu, beq resolution and the EX/MEM register
`default_nettype none
`timescale 1ns/1ns

module execute_stage (
    input  logic            clk,
    input  logic            reset,
    input  rv_pkg::id_ex_t  id_ex,
    input  rv_pkg::mem_wb_t mem_wb,
    output rv_pkg::ex_mem_t ex_mem,
    output logic            redirect,
    output rv_pkg::pc_t     redirect_pc
);
    import rv_pkg::*;

    word_t op_a;
    word_t op_b;
    word_t alu_b;
    word_t alu_res;

    // younger producer first, x0 is never forwarded
    function automatic word_t fwd(reg_idx_t idx, word_t decoded, ex_mem_t em, mem_wb_t mw);
        word_t val;
        val = decoded;
        if (idx != '0) begin
            if (em.valid && em.reg_write && (em.rd == idx)) begin
                val = em.alu_res;
            end else if (mw.valid && mw.reg_write && (mw.rd == idx)) begin
                val = mw.data;
            end
        end
        return val;
    endfunction

    always_comb begin
        op_a  = fwd(id_ex.rs1, id_ex.rs1_val, ex_mem, mem_wb);
        op_b  = fwd(id_ex.rs2, id_ex.rs2_val, ex_mem, mem_wb);
        // loads and stores add the offset here
        alu_b = id_ex.use_imm ? id_ex.imm : op_b;
        if (id_ex.alu_op == alu_sub) begin
            alu_res = op_a - alu_b;
        end else begin
            alu_res = op_a + alu_b;
        end
    end

    // beq taken when forwarded operands match
    assign redirect    = id_ex.valid && id_ex.branch && (op_a == op_b);
    // target wraps inside the 8-bit pc space
    assign redirect_pc = id_ex.pc + pc_t'(id_ex.imm);

    always_ff @(posedge clk) begin
        ex_mem.valid      <= id_ex.valid;
        ex_mem.rd         <= id_ex.rd;
        ex_mem.alu_res    <= alu_res;
        // store data after forwarding
        ex_mem.store_data <= op_b;
        ex_mem.reg_write  <= id_ex.reg_write;
        ex_mem.mem_read   <= id_ex.mem_read;
        ex_mem.mem_write  <= id_ex.mem_write;
        if (reset) begin
            ex_mem.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== memory_stage.sv ====
// memory stage with word data ram and the MEM/WB register driving write-back
`default_nettype none
`timescale 1ns/1ns

`include "rv_settings.svh"

module memory_stage (
    input  logic            clk,
    input  logic            reset,
    input  rv_pkg::ex_mem_t ex_mem,
    output rv_pkg::mem_wb_t mem_wb,
    output logic            wb_valid,
    output rv_pkg::reg_idx_t wb_rd,
    output rv_pkg::word_t   wb_data
);
    import rv_pkg::*;

    localparam int unsigned addr_w = $clog2(`RV_DMEM_WORDS);

    word_t             dmem [`RV_DMEM_WORDS];
    logic [addr_w-1:0] word_addr;

    // drop byte offset, upper bits wrap
    assign word_addr = ex_mem.alu_res[addr_w+1:2];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `RV_DMEM_WORDS; i++) begin
                dmem[i] <= '0;
            end
        end else if (ex_mem.valid && ex_mem.mem_write) begin
            dmem[word_addr] <= ex_mem.store_data;
        end
    end

    // load data or alu result into write-back
    always_ff @(posedge clk) begin
        mem_wb.valid     <= ex_mem.valid;
        mem_wb.rd        <= ex_mem.rd;
        mem_wb.reg_write <= ex_mem.reg_write;
        mem_wb.data      <= ex_mem.mem_read ? dmem[word_addr] : ex_mem.alu_res;
        if (reset) begin
            mem_wb.valid <= 1'b0;
        end
    end

    // one pulse per retired register write, never x0
    assign wb_valid = mem_wb.valid && mem_wb.reg_write && (mem_wb.rd != '0);
    assign wb_rd    = mem_wb.rd;
    assign wb_data  = mem_wb.data;

endmodule

`default_nettype wire

// ==== rv_core.sv ====
// five-stage rv32i subset core chaining fetch, decode, execute and memory
`default_nettype none
`timescale 1ns/1ns

module rv_core (
    input  logic             clk,
    input  logic             reset,
    input  rv_pkg::word_t    imem_data,
    output rv_pkg::pc_t      imem_addr,
    output logic             wb_valid,
    output rv_pkg::reg_idx_t wb_rd,
    output rv_pkg::word_t    wb_data
);
    import rv_pkg::*;

    // forward path between stages
    if_id_t  if_id;
    id_ex_t  id_ex;
    ex_mem_t ex_mem;
    mem_wb_t mem_wb;

    // hazard and branch feedback
    logic stall;
    logic redirect;
    pc_t  redirect_pc;

    fetch_stage fetch_stage_inst (
        .clk         (clk),
        .reset       (reset),
        .imem_data   (imem_data),
        .stall       (stall),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .imem_addr   (imem_addr),
        .if_id       (if_id)
    );

    // taken branch also flushes ID
    decode_stage decode_stage_inst (
        .clk    (clk),
        .reset  (reset),
        .if_id  (if_id),
        .flush  (redirect),
        .mem_wb (mem_wb),
        .id_ex  (id_ex),
        .stall  (stall)
    );

    execute_stage execute_stage_inst (
        .clk         (clk),
        .reset       (reset),
        .id_ex       (id_ex),
        .mem_wb      (mem_wb),
        .ex_mem      (ex_mem),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

    // MEM/WB also feeds the register file and forwarding
    memory_stage memory_stage_inst (
        .clk      (clk),
        .reset    (reset),
        .ex_mem   (ex_mem),
        .mem_wb   (mem_wb),
        .wb_valid (wb_valid),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data)
    );

endmodule

`default_nettype wire

// ==== rv_core_sva.sv ====
// bound assertions on reset, branch flush and x0 write-back of the rv32i core
`default_nettype none
`timescale 1ns/1ns

module rv_core_sva (
    input logic             clk,
    input logic             reset,
    input logic             wb_valid,
    input logic             redirect,
    input logic             id_ex_valid,
    input rv_pkg::reg_idx_t id_ex_rd
);
    // no write-back pulse during reset or in the first cycle after it
    reset_quiet: assert property (@(posedge clk) reset |=> !wb_valid)
        else $error("write-back pulse during or right after reset");

    // an x0 destination in ID/EX reaches the port two cycles later, silently
    no_x0_write: assert property (@(posedge clk) disable iff (reset)
        (id_ex_valid && (id_ex_rd == '0)) |-> ##2 !wb_valid)
        else $error("write-back pulse for an instruction that targets x0");

    // taken branch leaves a bubble in ID/EX
    flush_bubble: assert property (@(posedge clk) disable iff (reset)
        redirect |=> !id_ex_valid)
        else $error("ID/EX still valid in the cycle after a redirect");

endmodule

bind rv_core rv_core_sva rv_core_sva_inst (
    .clk         (clk),
    .reset       (reset),
    .wb_valid    (wb_valid),
    .redirect    (redirect),
    .id_ex_valid (id_ex.valid),
    .id_ex_rd    (id_ex.rd)
);

`default_nettype wire

// ==== tb_rv_core.sv ====
// testbench for the rv32i pipeline core, program table against expected write-backs
`default_nettype none
`timescale 1ns/1ns

module tb_rv_core;

    // isa opcodes
    localparam logic [6:0] opc_r      = 7'b0110011;
    localparam logic [6:0] opc_imm    = 7'b0010011;
    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_store  = 7'b0100011;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_undef  = 7'b1111111;
    // addi x0, x0, 0
    localparam logic [31:0] nop_word  = 32'h0000_0013;

    localparam int n_exp        = 17;
    localparam int wait_cycles  = 20;
    // short of the 8-bit pc wrapping back to the program start
    localparam int drain_cycles = 20;

    logic        clk;
    logic        reset;
    logic [31:0] imem_data;
    logic [7:0]  imem_addr;
    logic        wb_valid;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;

    logic [31:0] prog [64];
    logic [4:0]  exp_rd [n_exp];
    logic [31:0] exp_data [n_exp];
    int          pass_count;
    int          fail_count;

    rv_core rv_core_inst (
        .clk       (clk),
        .reset     (reset),
        .imem_data (imem_data),
        .imem_addr (imem_addr),
        .wb_valid  (wb_valid),
        .wb_rd     (wb_rd),
        .wb_data   (wb_data)
    );

    // instruction encoders, funct3 fixed where the subset has one value
    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [4:0] rd,
                                           input logic [6:0] op);
        return {f7, rs2, rs1, 3'b000, rd, op};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opc_store};
    endfunction

    // beq, byte offset with bit 0 dropped
    function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1);
        return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], opc_branch};
    endfunction

    task automatic fill_program();
        for (int a = 0; a < 64; a++) begin
            prog[a] = nop_word;
        end
        // arithmetic with forwarding one and two apart
        prog[0]  = i_type(12'sd5, 5'd0, 3'b000, 5'd1, opc_imm);
        prog[1]  = i_type(-12'sd3, 5'd0, 3'b000, 5'd2, opc_imm);
        prog[2]  = r_type(7'b0000000, 5'd2, 5'd1, 5'd3, opc_r);
        prog[3]  = r_type(7'b0100000, 5'd2, 5'd1, 5'd4, opc_r);
        prog[4]  = r_type(7'b0100000, 5'd3, 5'd4, 5'd5, opc_r);
        // write to x0 then read it
        prog[5]  = i_type(12'sd7, 5'd0, 3'b000, 5'd0, opc_imm);
        prog[6]  = r_type(7'b0000000, 5'd5, 5'd0, 5'd6, opc_r);
        // stores to words 0..2
        prog[7]  = s_type(12'sd0, 5'd1, 5'd0);
        prog[8]  = s_type(12'sd4, 5'd4, 5'd0);
        prog[9]  = s_type(12'sd8, 5'd2, 5'd0);
        // load-use pair
        prog[10] = i_type(12'sd4, 5'd0, 3'b010, 5'd7, opc_load);
        prog[11] = i_type(12'sd100, 5'd7, 3'b000, 5'd8, opc_imm);
        // word 3 never written
        prog[12] = i_type(12'sd0, 5'd0, 3'b010, 5'd9, opc_load);
        prog[13] = i_type(12'sd12, 5'd0, 3'b010, 5'd10, opc_load);
        prog[14] = i_type(12'sd8, 5'd0, 3'b010, 5'd11, opc_load);
        prog[15] = r_type(7'b0000000, 5'd9, 5'd11, 5'd12, opc_r);
        prog[16] = r_type(7'b0000000, 5'd2, 5'd1, 5'd13, opc_undef);
        // beq not taken, then taken over two shadows to index 22
        prog[17] = b_type(13'sd12, 5'd4, 5'd1);
        prog[18] = i_type(12'sd1, 5'd0, 3'b000, 5'd13, opc_imm);
        prog[19] = b_type(13'sd12, 5'd6, 5'd5);
        prog[20] = i_type(12'sd99, 5'd0, 3'b000, 5'd14, opc_imm);
        prog[21] = i_type(12'sd98, 5'd0, 3'b000, 5'd15, opc_imm);
        prog[22] = i_type(12'sd1, 5'd14, 3'b000, 5'd16, opc_imm);
        // taken beq on a forwarded operand, target is the second shadow
        prog[23] = i_type(12'sd6, 5'd0, 3'b000, 5'd17, opc_imm);
        prog[24] = b_type(13'sd8, 5'd5, 5'd17);
        prog[25] = i_type(12'sd55, 5'd0, 3'b000, 5'd18, opc_imm);
        prog[26] = i_type(-12'sd6, 5'd17, 3'b000, 5'd19, opc_imm);
        prog[27] = r_type(7'b0000000, 5'd19, 5'd16, 5'd20, opc_r);
    endtask

    // retirement order worked out by hand
    task automatic build_expected();
        exp_rd[0]  = 5'd1;  exp_data[0]  = 32'h0000_0005;
        exp_rd[1]  = 5'd2;  exp_data[1]  = 32'hFFFF_FFFD;
        exp_rd[2]  = 5'd3;  exp_data[2]  = 32'h0000_0002;
        exp_rd[3]  = 5'd4;  exp_data[3]  = 32'h0000_0008;
        exp_rd[4]  = 5'd5;  exp_data[4]  = 32'h0000_0006;
        exp_rd[5]  = 5'd6;  exp_data[5]  = 32'h0000_0006;
        exp_rd[6]  = 5'd7;  exp_data[6]  = 32'h0000_0008;
        exp_rd[7]  = 5'd8;  exp_data[7]  = 32'h0000_006C;
        exp_rd[8]  = 5'd9;  exp_data[8]  = 32'h0000_0005;
        exp_rd[9]  = 5'd10; exp_data[9]  = 32'h0000_0000;
        exp_rd[10] = 5'd11; exp_data[10] = 32'hFFFF_FFFD;
        exp_rd[11] = 5'd12; exp_data[11] = 32'h0000_0002;
        exp_rd[12] = 5'd13; exp_data[12] = 32'h0000_0001;
        exp_rd[13] = 5'd16; exp_data[13] = 32'h0000_0001;
        exp_rd[14] = 5'd17; exp_data[14] = 32'h0000_0006;
        exp_rd[15] = 5'd19; exp_data[15] = 32'h0000_0000;
        exp_rd[16] = 5'd20; exp_data[16] = 32'h0000_0001;
    endtask

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    // combinational imem seen by the core, updated 2 ns after the edge
    always @(posedge clk) begin
        #2;
        imem_data <= prog[imem_addr[7:2]];
    end

    initial begin
        int waited;
        int extra;
        bit got;
        bit timed_out;
        reset      = 1'b1;
        imem_data  = nop_word;
        pass_count = 0;
        fail_count = 0;
        timed_out  = 1'b0;
        fill_program();
        build_expected();
        repeat (4) @(posedge clk);
        #2;
        reset = 1'b0;

        // first fetch out of reset comes from address zero
        @(negedge clk);
        if (imem_addr !== 8'h00) begin
            $display("[ERROR] %0t: fetch address after reset is %h, expected 00",
                     $time, imem_addr);
            fail_count++;
        end else begin
            $display("reset: fetch address %h ok", imem_addr);
            pass_count++;
        end

        // outputs sampled on the falling edge
        for (int i = 0; i < n_exp && !timed_out; i++) begin
            waited = 0;
            got    = 1'b0;
            while (!got && waited < wait_cycles) begin
                @(negedge clk);
                waited++;
                got = wb_valid;
            end
            if (!got) begin
                $display("timeout: no write-back for entry %0d (x%0d) within %0d cycles",
                         i, exp_rd[i], wait_cycles);
                fail_count++;
                timed_out = 1'b1;
            end else if (wb_rd !== exp_rd[i] || wb_data !== exp_data[i]) begin
                $display("[ERROR] %0t: entry %0d expected x%0d = %h, got x%0d = %h",
                         $time, i, exp_rd[i], exp_data[i], wb_rd, wb_data);
                fail_count++;
            end else begin
                $display("entry %0d: x%0d = %h ok", i, wb_rd, wb_data);
                pass_count++;
            end
        end

        // trailing nops must stay silent
        if (!timed_out) begin
            extra = 0;
            for (int c = 0; c < drain_cycles; c++) begin
                @(negedge clk);
                if (wb_valid) begin
                    $display("[ERROR] %0t: unexpected write-back x%0d = %h",
                             $time, wb_rd, wb_data);
                    extra++;
                end
            end
            if (extra == 0) begin
                $display("drain: no extra write-back in %0d cycles", drain_cycles);
                pass_count++;
            end else begin
                fail_count++;
            end
        end

        $display("checks: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== rv_core.f ====
+incdir+.
rv_pkg.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
memory_stage.sv
rv_core.sv
rv_core_sva.sv
tb_rv_core.sv

// ==== Makefile ====
# Verilator build and run of the rv_core testbench

VERILATOR ?= verilator
TOP       ?= tb_rv_core
FILELIST  ?= rv_core.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns

SOURCES := $(filter-out +incdir+%,$(shell cat $(FILELIST)))
HEADERS := rv_settings.svh
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source, the header or the file list changes
$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "^RESULT: PASS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
